//--- hw/sig_ver_settings.svh
`ifndef SIG_VER_SETTINGS_SVH
`define SIG_VER_SETTINGS_SVH

// Stream and scalar widths
`define DAT_BITS 64
`define KEY_BITS 256
`define KEY_WORDS 4

// Register file depth in 64-bit words
`define REG_DEPTH 32

// Word addresses of the stored command fields
`define REG_ADDR_CMD 0
`define REG_ADDR_S 1
`define REG_ADDR_R 5
`define REG_ADDR_HASH 9
`define REG_ADDR_Q 13

// Data words after the index word: s, r, hash, Q.x, Q.y
`define SIG_WORDS 20

// Command and reply codes
`define CMD_VERIFY_SIG 16'h0100
`define RPL_VERIFY_SIG 16'h8100

// Reply length in words
`define RPL_WORDS 7

// secp256k1 group order
`define CURVE_N 256'hFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFEBAAEDCE6AF48A03BBFD25E8CD0364141

`endif

//--- hw/sig_ver_pkg.sv
`include "sig_ver_settings.svh"

package sig_ver_pkg;

  // One 256-bit scalar
  typedef logic [`KEY_BITS-1:0] key_t;

  // Command header, code in the low bits
  typedef struct packed {
    logic [15:0] rsvd;
    logic [31:0] len;
    logic [15:0] cmd;
  } header_t;

  // First word of a command is a header, later words are plain data
  typedef union packed {
    header_t              hdr;
    logic [`DAT_BITS-1:0] raw;
  } cmd_word_u;

  // One beat on the command or reply stream
  typedef struct packed {
    logic [`DAT_BITS-1:0] dat;
    logic                 sop;
    logic                 eop;
  } stream_beat_t;

  // Fields the checker needs from a verify command
  typedef struct packed {
    logic [`DAT_BITS-1:0] index;
    key_t                 s;
    key_t                 r;
  } sig_job_t;

  typedef struct packed {
    logic [5:0] rsvd;
    logic       out_of_range_r;
    logic       out_of_range_s;
  } ver_status_t;

  typedef struct packed {
    logic [`DAT_BITS-1:0] index;
    ver_status_t          status;
    key_t                 s_inv;
  } ver_result_t;

endpackage

//--- hw/reg_file.sv
`timescale 1ns/1ps
`include "sig_ver_settings.svh"

module reg_file (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  logic                          i_wr_en,
  input  logic [$clog2(`REG_DEPTH)-1:0] i_wr_addr,
  input  logic [`DAT_BITS-1:0]          i_wr_dat,
  input  logic                          i_mm_rd,
  input  logic [7:0]                    i_mm_addr,
  output logic [`DAT_BITS-1:0]          o_mm_dat,
  output logic                          o_mm_dat_val
);

  localparam int ADDR_BITS = $clog2(`REG_DEPTH);

  logic [`DAT_BITS-1:0] mem [`REG_DEPTH];
  logic [`DAT_BITS-1:0] rd_word;
  logic                 rd_d1;

  // Port A, write only
  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_dat;
    end
  end

  // Port B, byte address to word, read register then output register
  always_ff @(posedge i_clk) begin
    rd_word <= mem[i_mm_addr[ADDR_BITS+2:3]];
    if (rd_d1) begin
      o_mm_dat <= rd_word;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rd_d1        <= 1'b0;
      o_mm_dat_val <= 1'b0;
    end else begin
      rd_d1        <= i_mm_rd;
      o_mm_dat_val <= rd_d1;
    end
  end

endmodule

//--- hw/bin_inv.sv
`timescale 1ns/1ps
`include "sig_ver_settings.svh"

module bin_inv
  import sig_ver_pkg::*;
(
  input  logic i_clk,
  input  logic i_rst,
  input  key_t i_dat,
  input  logic i_val,
  output logic o_rdy,
  output key_t o_dat,
  output logic o_val,
  input  logic i_rdy
);

  localparam key_t N = `CURVE_N;

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } state_t;

  state_t state;
  key_t   u;
  key_t   v;
  key_t   x1;
  key_t   x2;
  logic   found;

  // x/2 mod n, n is odd so an odd x gets n added first
  function automatic key_t half_mod(input key_t x);
    logic [`KEY_BITS:0] sum;
    sum = x[0] ? ({1'b0, x} + {1'b0, N}) : {1'b0, x};
    return sum[`KEY_BITS:1];
  endfunction

  // a - b mod n, both already below n
  function automatic key_t sub_mod(input key_t a, input key_t b);
    return (a >= b) ? (a - b) : (a - b + N);
  endfunction

  assign o_rdy = (state == IDLE);
  assign o_val = (state == DONE);
  assign found = (u == key_t'(1)) || (v == key_t'(1));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (i_val) state <= BUSY;
        BUSY:    if (found) state <= DONE;
        DONE:    if (i_rdy) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Invariants x1*a = u and x2*a = v (mod n)
  always_ff @(posedge i_clk) begin
    if (state == IDLE && i_val) begin
      u  <= i_dat;
      v  <= N;
      x1 <= key_t'(1);
      x2 <= '0;
    end else if (state == BUSY) begin
      if (u == key_t'(1)) begin
        o_dat <= x1;
      end else if (v == key_t'(1)) begin
        o_dat <= x2;
      end else if (!u[0]) begin
        u  <= u >> 1;
        x1 <= half_mod(x1);
      end else if (!v[0]) begin
        v  <= v >> 1;
        x2 <= half_mod(x2);
      end else if (u >= v) begin
        // Difference of two odd values is even, halve in the same step
        u  <= (u - v) >> 1;
        x1 <= half_mod(sub_mod(x1, x2));
      end else begin
        v  <= (v - u) >> 1;
        x2 <= half_mod(sub_mod(x2, x1));
      end
    end
  end

endmodule

//--- hw/cmd_parser.sv
`timescale 1ns/1ps
`include "sig_ver_settings.svh"

module cmd_parser
  import sig_ver_pkg::*;
(
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  stream_beat_t                  i_cmd,
  input  logic                          i_cmd_val,
  output logic                          o_cmd_rdy,
  input  logic                          i_done,
  output logic                          o_wr_en,
  output logic [$clog2(`REG_DEPTH)-1:0] o_wr_addr,
  output logic [`DAT_BITS-1:0]          o_wr_dat,
  output sig_job_t                      o_job,
  output logic                          o_job_val
);

  localparam int ADDR_BITS = $clog2(`REG_DEPTH);

  typedef enum logic [2:0] {
    IDLE,
    GET_INDEX,
    PARSE,
    WAIT_DONE,
    IGNORE
  } state_t;

  state_t                 state;
  cmd_word_u              cmd_w;
  logic                   xfer;
  logic [4:0]             cnt;
  logic [ADDR_BITS-1:0]   word_addr;

  assign cmd_w     = i_cmd.dat;
  // Held off while a job is being checked and replied to
  assign o_cmd_rdy = (state != WAIT_DONE);
  assign xfer      = i_cmd_val && o_cmd_rdy;

  // Data word count to register address
  always_comb begin
    case (cnt[4:2])
      3'd0:    word_addr = ADDR_BITS'(`REG_ADDR_S + cnt[1:0]);
      3'd1:    word_addr = ADDR_BITS'(`REG_ADDR_R + cnt[1:0]);
      3'd2:    word_addr = ADDR_BITS'(`REG_ADDR_HASH + cnt[1:0]);
      default: word_addr = ADDR_BITS'(`REG_ADDR_Q + cnt - 12);
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= IDLE;
      cnt       <= '0;
      o_wr_en   <= 1'b0;
      o_job_val <= 1'b0;
    end else begin
      o_wr_en   <= 1'b0;
      o_job_val <= 1'b0;
      case (state)
        IDLE: begin
          if (xfer) begin
            if (cmd_w.hdr.cmd == `CMD_VERIFY_SIG) begin
              o_wr_en <= 1'b1;
              state   <= GET_INDEX;
            end else if (!i_cmd.eop) begin
              state <= IGNORE;
            end
          end
        end
        GET_INDEX: begin
          if (xfer) begin
            cnt   <= '0;
            state <= PARSE;
          end
        end
        PARSE: begin
          if (xfer) begin
            o_wr_en <= 1'b1;
            cnt     <= cnt + 5'd1;
            if (cnt == 5'(`SIG_WORDS - 1)) begin
              o_job_val <= 1'b1;
              state     <= WAIT_DONE;
            end
          end
        end
        WAIT_DONE: begin
          if (i_done) begin
            state <= IDLE;
          end
        end
        IGNORE: begin
          // Drain until the end of the foreign command
          if (xfer && i_cmd.eop) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Write data and job fields
  always_ff @(posedge i_clk) begin
    if (xfer) begin
      o_wr_dat  <= cmd_w.raw;
      o_wr_addr <= (state == IDLE) ? ADDR_BITS'(`REG_ADDR_CMD) : word_addr;
      if (state == GET_INDEX) begin
        o_job.index <= cmd_w.raw;
      end
      if (state == PARSE) begin
        if (cnt < 5'(`KEY_WORDS)) begin
          o_job.s[cnt[1:0]*`DAT_BITS +: `DAT_BITS] <= cmd_w.raw;
        end else if (cnt < 5'(2*`KEY_WORDS)) begin
          o_job.r[cnt[1:0]*`DAT_BITS +: `DAT_BITS] <= cmd_w.raw;
        end
      end
    end
  end

endmodule

//--- hw/sig_ver_ctrl.sv
`timescale 1ns/1ps
`include "sig_ver_settings.svh"

module sig_ver_ctrl
  import sig_ver_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst,
  input  sig_job_t    i_job,
  input  logic        i_job_val,
  output key_t        o_inv_dat,
  output logic        o_inv_val,
  input  logic        i_inv_rdy,
  input  key_t        i_inv_res,
  input  logic        i_inv_res_val,
  output logic        o_inv_res_rdy,
  output ver_result_t o_result,
  output logic        o_result_val
);

  typedef enum logic {
    IDLE,
    INV_WAIT
  } state_t;

  state_t      state;
  ver_status_t status;
  logic        job_take;

  // Scalars must lie in [1, n-1]
  always_comb begin
    status                = '0;
    status.out_of_range_s = (i_job.s >= `CURVE_N) || (i_job.s == '0);
    status.out_of_range_r = (i_job.r >= `CURVE_N) || (i_job.r == '0);
  end

  assign job_take      = i_job_val && (state == IDLE);
  assign o_inv_res_rdy = (state == INV_WAIT);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state        <= IDLE;
      o_inv_val    <= 1'b0;
      o_result_val <= 1'b0;
    end else begin
      o_result_val <= 1'b0;
      if (o_inv_val && i_inv_rdy) begin
        o_inv_val <= 1'b0;
      end
      case (state)
        IDLE: begin
          if (i_job_val) begin
            if (status.out_of_range_s) begin
              // No inverse for a bad s, answer at once
              o_result_val <= 1'b1;
            end else begin
              o_inv_val <= 1'b1;
              state     <= INV_WAIT;
            end
          end
        end
        INV_WAIT: begin
          if (i_inv_res_val) begin
            o_result_val <= 1'b1;
            state        <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (job_take) begin
      o_result.index  <= i_job.index;
      o_result.status <= status;
      o_result.s_inv  <= '0;
      o_inv_dat       <= i_job.s;
    end else if (o_inv_res_rdy && i_inv_res_val) begin
      o_result.s_inv <= i_inv_res;
    end
  end

endmodule

//--- hw/reply_builder.sv
`timescale 1ns/1ps
`include "sig_ver_settings.svh"

module reply_builder
  import sig_ver_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_rst,
  input  ver_result_t  i_result,
  input  logic         i_result_val,
  output stream_beat_t o_rpl,
  output logic         o_rpl_val,
  input  logic         i_rpl_rdy,
  output logic         o_done
);

  localparam int CNT_BITS = $clog2(`RPL_WORDS + 1);

  logic [`RPL_WORDS*`DAT_BITS-1:0] words;
  logic [CNT_BITS-1:0]             left;
  header_t                         rpl_hdr;
  logic                            xfer;
  logic                            load;

  assign xfer = o_rpl_val && i_rpl_rdy;
  assign load = i_result_val && !o_rpl_val;

  always_comb begin
    rpl_hdr     = '0;
    rpl_hdr.cmd = `RPL_VERIFY_SIG;
    rpl_hdr.len = 32'(`RPL_WORDS * 8);
  end

  // Current word sits in the low bits of the shift register
  always_comb begin
    o_rpl.dat = words[`DAT_BITS-1:0];
    o_rpl.sop = (left == CNT_BITS'(`RPL_WORDS));
    o_rpl.eop = (left == CNT_BITS'(1));
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rpl_val <= 1'b0;
      left      <= '0;
      o_done    <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (load) begin
        o_rpl_val <= 1'b1;
        left      <= CNT_BITS'(`RPL_WORDS);
      end else if (xfer) begin
        left <= left - CNT_BITS'(1);
        if (left == CNT_BITS'(1)) begin
          o_rpl_val <= 1'b0;
          o_done    <= 1'b1;
        end
      end
    end
  end

  // Header, index, status, then s_inv low word first
  always_ff @(posedge i_clk) begin
    if (load) begin
      words <= {i_result.s_inv,
                {(`DAT_BITS - $bits(ver_status_t)){1'b0}}, i_result.status,
                i_result.index,
                rpl_hdr};
    end else if (xfer) begin
      words <= words >> `DAT_BITS;
    end
  end

endmodule

//--- hw/sig_ver_top.sv
`timescale 1ns/1ps
`include "sig_ver_settings.svh"

module sig_ver_top
  import sig_ver_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  stream_beat_t         i_cmd,
  input  logic                 i_cmd_val,
  output logic                 o_cmd_rdy,
  output stream_beat_t         o_rpl,
  output logic                 o_rpl_val,
  input  logic                 i_rpl_rdy,
  input  logic                 i_mm_rd,
  input  logic [7:0]           i_mm_addr,
  output logic [`DAT_BITS-1:0] o_mm_dat,
  output logic                 o_mm_dat_val
);

  logic                          wr_en;
  logic [$clog2(`REG_DEPTH)-1:0] wr_addr;
  logic [`DAT_BITS-1:0]          wr_dat;
  sig_job_t                      job;
  logic                          job_val;
  key_t                          inv_dat;
  logic                          inv_val;
  logic                          inv_rdy;
  key_t                          inv_res;
  logic                          inv_res_val;
  logic                          inv_res_rdy;
  ver_result_t                   result;
  logic                          result_val;
  logic                          done;

  cmd_parser u_cmd_parser (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_cmd     (i_cmd),
    .i_cmd_val (i_cmd_val),
    .o_cmd_rdy (o_cmd_rdy),
    .i_done    (done),
    .o_wr_en   (wr_en),
    .o_wr_addr (wr_addr),
    .o_wr_dat  (wr_dat),
    .o_job     (job),
    .o_job_val (job_val)
  );

  reg_file u_reg_file (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_wr_en      (wr_en),
    .i_wr_addr    (wr_addr),
    .i_wr_dat     (wr_dat),
    .i_mm_rd      (i_mm_rd),
    .i_mm_addr    (i_mm_addr),
    .o_mm_dat     (o_mm_dat),
    .o_mm_dat_val (o_mm_dat_val)
  );

  bin_inv u_bin_inv (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_dat (inv_dat),
    .i_val (inv_val),
    .o_rdy (inv_rdy),
    .o_dat (inv_res),
    .o_val (inv_res_val),
    .i_rdy (inv_res_rdy)
  );

  sig_ver_ctrl u_sig_ver_ctrl (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_job         (job),
    .i_job_val     (job_val),
    .o_inv_dat     (inv_dat),
    .o_inv_val     (inv_val),
    .i_inv_rdy     (inv_rdy),
    .i_inv_res     (inv_res),
    .i_inv_res_val (inv_res_val),
    .o_inv_res_rdy (inv_res_rdy),
    .o_result      (result),
    .o_result_val  (result_val)
  );

  reply_builder u_reply_builder (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_result     (result),
    .i_result_val (result_val),
    .o_rpl        (o_rpl),
    .o_rpl_val    (o_rpl_val),
    .i_rpl_rdy    (i_rpl_rdy),
    .o_done       (done)
  );

endmodule

//--- tb/sig_ver_properties.sv
`timescale 1ns/1ps

module sig_ver_properties
  import sig_ver_pkg::*;
(
  input logic         i_clk,
  input logic         i_rst,
  input logic         o_cmd_rdy,
  input stream_beat_t o_rpl,
  input logic         o_rpl_val,
  input logic         i_rpl_rdy,
  input logic         i_mm_rd,
  input logic         o_mm_dat_val
);

  // Failed property count, read by the testbench at the end of the run
  int fail_cnt = 0;

  // A stalled reply beat stays valid and unchanged
  rpl_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_rpl_val && !i_rpl_rdy) |=> (o_rpl_val && $stable(o_rpl)))
    else begin
      $error("reply beat changed while the sink was stalling");
      fail_cnt++;
    end

  // Debug data valid exactly two cycles after the read strobe
  mm_latency: assert property (@(posedge i_clk) disable iff (i_rst)
    o_mm_dat_val == $past(i_mm_rd, 2))
    else begin
      $error("debug read data valid not two cycles after the read strobe");
      fail_cnt++;
    end

  // No new command accepted while a reply is going out
  cmd_blocked: assert property (@(posedge i_clk) disable iff (i_rst)
    o_rpl_val |-> !o_cmd_rdy)
    else begin
      $error("command stream ready while a reply is pending");
      fail_cnt++;
    end

endmodule

bind sig_ver_top sig_ver_properties u_props (
  .i_clk        (i_clk),
  .i_rst        (i_rst),
  .o_cmd_rdy    (o_cmd_rdy),
  .o_rpl        (o_rpl),
  .o_rpl_val    (o_rpl_val),
  .i_rpl_rdy    (i_rpl_rdy),
  .i_mm_rd      (i_mm_rd),
  .o_mm_dat_val (o_mm_dat_val)
);

//--- tb/sig_ver_tb.sv
`timescale 1ns/1ps
`include "sig_ver_settings.svh"

module sig_ver_tb
  import sig_ver_pkg::*;
();

  localparam key_t N          = `CURVE_N;
  localparam int   WAIT_LIMIT = 2000;

  logic                 i_clk;
  logic                 i_rst;
  stream_beat_t         i_cmd;
  logic                 i_cmd_val;
  logic                 o_cmd_rdy;
  stream_beat_t         o_rpl;
  logic                 o_rpl_val;
  logic                 i_rpl_rdy;
  logic                 i_mm_rd;
  logic [7:0]           i_mm_addr;
  logic [`DAT_BITS-1:0] o_mm_dat;
  logic                 o_mm_dat_val;

  logic [63:0] rng;
  int          err_cnt;
  int          err_base;
  int          test_cnt;
  int          test_fail_cnt;
  // Words as stored in the register file with the header at address 0
  logic [63:0] sent [0:`SIG_WORDS];
  logic [63:0] rpl_words [0:`RPL_WORDS-1];

  sig_ver_top DUT (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_cmd        (i_cmd),
    .i_cmd_val    (i_cmd_val),
    .o_cmd_rdy    (o_cmd_rdy),
    .o_rpl        (o_rpl),
    .o_rpl_val    (o_rpl_val),
    .i_rpl_rdy    (i_rpl_rdy),
    .i_mm_rd      (i_mm_rd),
    .i_mm_addr    (i_mm_addr),
    .o_mm_dat     (o_mm_dat),
    .o_mm_dat_val (o_mm_dat_val)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  function automatic logic [63:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 7);
    rng = rng ^ (rng << 17);
    return rng;
  endfunction

  // Random scalar in [1, n-1]
  function automatic key_t rand_scalar();
    key_t k;
    for (int i = 0; i < `KEY_WORDS; i++) begin
      k[i*64 +: 64] = next_rand();
    end
    if (k >= N) begin
      k = k - N;
    end
    if (k == '0) begin
      k = key_t'(1);
    end
    return k;
  endfunction

  // Reference product a*b mod n at full width
  function automatic key_t mul_mod_n(input key_t a, input key_t b);
    logic [511:0] prod;
    prod = {256'b0, a} * {256'b0, b};
    return key_t'(prod % {256'b0, N});
  endfunction

  function automatic int total_errors();
    return err_cnt + DUT.u_props.fail_cnt;
  endfunction

  task automatic check_val(input string name, input key_t exp, input key_t act);
    assert (act == exp) else begin
      $display("mismatch at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic timeout_exit(input string what);
    $display("timeout at %0t ns while waiting for %s", $time, what);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  // Called on a falling edge and returns on the falling edge after the transfer
  task automatic send_word(input logic [63:0] dat, input logic sop, input logic eop);
    int waited;
    waited = 0;
    i_cmd.dat = dat;
    i_cmd.sop = sop;
    i_cmd.eop = eop;
    i_cmd_val = 1'b1;
    while (!o_cmd_rdy) begin
      @(negedge i_clk);
      waited++;
      if (waited > WAIT_LIMIT) timeout_exit("command stream ready");
    end
    @(negedge i_clk);
    i_cmd_val = 1'b0;
  endtask

  task automatic collect_reply(input bit rnd_rdy);
    int          got;
    int          waited;
    logic [63:0] rv;
    got    = 0;
    waited = 0;
    while (got < `RPL_WORDS) begin
      rv        = next_rand();
      i_rpl_rdy = rnd_rdy ? rv[0] : 1'b1;
      if (o_rpl_val && i_rpl_rdy) begin
        rpl_words[got] = o_rpl.dat;
        check_val("o_rpl.sop", key_t'(got == 0), key_t'(o_rpl.sop));
        check_val("o_rpl.eop", key_t'(got == `RPL_WORDS - 1), key_t'(o_rpl.eop));
        got++;
        waited = 0;
      end else begin
        waited++;
        if (waited > WAIT_LIMIT) timeout_exit("reply word");
      end
      @(negedge i_clk);
    end
    i_rpl_rdy = 1'b0;
  endtask

  task automatic run_verify(input key_t s, input key_t r, input bit rnd_rdy);
    header_t     hdr;
    header_t     rpl_hdr;
    ver_status_t st;
    logic [63:0] index;
    key_t        s_inv;
    hdr     = '0;
    hdr.cmd = `CMD_VERIFY_SIG;
    hdr.len = 32'((`SIG_WORDS + 2) * 8);
    index   = next_rand();
    sent[`REG_ADDR_CMD] = hdr;
    for (int i = 0; i < `KEY_WORDS; i++) begin
      sent[`REG_ADDR_S + i] = s[i*64 +: 64];
      sent[`REG_ADDR_R + i] = r[i*64 +: 64];
    end
    // Hash and public key are stored but not checked by the DUT
    for (int i = `REG_ADDR_HASH; i <= `SIG_WORDS; i++) begin
      sent[i] = next_rand();
    end
    send_word(sent[`REG_ADDR_CMD], 1'b1, 1'b0);
    send_word(index, 1'b0, 1'b0);
    for (int i = 1; i <= `SIG_WORDS; i++) begin
      send_word(sent[i], 1'b0, i == `SIG_WORDS);
    end
    collect_reply(rnd_rdy);

    rpl_hdr     = '0;
    rpl_hdr.cmd = `RPL_VERIFY_SIG;
    rpl_hdr.len = 32'(`RPL_WORDS * 8);
    st                = '0;
    st.out_of_range_s = (s >= N) || (s == '0);
    st.out_of_range_r = (r >= N) || (r == '0);
    s_inv = {rpl_words[6], rpl_words[5], rpl_words[4], rpl_words[3]};
    check_val("reply header", key_t'(rpl_hdr), key_t'(rpl_words[0]));
    check_val("reply index", key_t'(index), key_t'(rpl_words[1]));
    check_val("reply status", key_t'(st), key_t'(rpl_words[2]));
    if (st.out_of_range_s) begin
      check_val("s_inv", '0, s_inv);
    end else begin
      check_val("s*s_inv mod n", key_t'(1), mul_mod_n(s, s_inv));
      check_val("s_inv below n", key_t'(1), key_t'(s_inv < N));
    end
  endtask

  task automatic run_ignored();
    header_t hdr;
    hdr     = '0;
    hdr.cmd = 16'h0300;
    hdr.len = 32'((`SIG_WORDS + 2) * 8);
    send_word(hdr, 1'b1, 1'b0);
    // Same length as a verify command so that a misparsed header would end in a reply
    for (int i = 1; i < `SIG_WORDS + 2; i++) begin
      send_word(next_rand(), 1'b0, i == `SIG_WORDS + 1);
    end
    // Long enough to cover the worst inverse latency
    for (int i = 0; i < 2*`KEY_BITS + 16; i++) begin
      assert (!o_rpl_val) else begin
        $display("unexpected reply at %0t ns after an ignored command", $time);
        err_cnt++;
      end
      @(negedge i_clk);
    end
  endtask

  task automatic read_back();
    int waited;
    for (int a = 0; a <= `SIG_WORDS; a++) begin
      i_mm_rd   = 1'b1;
      i_mm_addr = 8'(a * 8);
      @(negedge i_clk);
      i_mm_rd = 1'b0;
      waited  = 0;
      while (!o_mm_dat_val) begin
        @(negedge i_clk);
        waited++;
        if (waited > WAIT_LIMIT) timeout_exit("debug read data");
      end
      check_val($sformatf("o_mm_dat[%0d]", a), key_t'(sent[a]), key_t'(o_mm_dat));
      @(negedge i_clk);
    end
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    if (total_errors() == err_base) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      test_fail_cnt++;
      $display("test %0d %s: %0d errors", test_cnt, name, total_errors() - err_base);
    end
    err_base = total_errors();
  endtask

  initial begin
    rng           = 64'd77706;
    err_cnt       = 0;
    err_base      = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    i_rst         = 1'b1;
    i_cmd         = '0;
    i_cmd_val     = 1'b0;
    i_rpl_rdy     = 1'b0;
    i_mm_rd       = 1'b0;
    i_mm_addr     = '0;
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    @(negedge i_clk);

    run_verify(rand_scalar(), rand_scalar(), 1'b0);
    finish_test("valid signature");
    read_back();
    finish_test("debug read");

    run_verify(N + key_t'(5), rand_scalar(), 1'b0);
    run_verify('0, rand_scalar(), 1'b0);
    run_verify(rand_scalar(), N, 1'b0);
    run_verify(rand_scalar(), '0, 1'b0);
    finish_test("out-of-range values");

    run_ignored();
    run_verify(rand_scalar(), rand_scalar(), 1'b0);
    finish_test("ignored command");

    for (int i = 0; i < 3; i++) begin
      run_verify(rand_scalar(), rand_scalar(), 1'b1);
    end
    finish_test("back-pressure");

    $display("tests run %0d, tests with errors %0d, errors %0d",
             test_cnt, test_fail_cnt, total_errors());
    if (test_fail_cnt == 0 && total_errors() == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+hw
hw/sig_ver_pkg.sv
hw/reg_file.sv
hw/bin_inv.sv
hw/cmd_parser.sv
hw/sig_ver_ctrl.sv
hw/reply_builder.sv
hw/sig_ver_top.sv
tb/sig_ver_properties.sv
tb/sig_ver_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module sig_ver_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

# Keep running after an assertion error so the testbench reaches its verdict
./obj_dir/Vsig_ver_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
  echo "simulation reported failure, see $LOG"
  exit 1
fi
echo "simulation finished without failure"
exit 0
